//--- verilog/bus_pkg.sv
/*
 * Bus widths and port types shared by the memory model and its users.
 * The RAM covers the low 64 KiB; the data address is 32 bits wide and
 * is decoded either as a RAM offset or as a peripheral region/offset.
 */
package bus_pkg;

  localparam int ram_addr_width    = 16;
  localparam int instr_rdata_width = 128;
  localparam int data_width        = 32;
  localparam int data_be_width     = data_width / 8;

  typedef struct packed {
    logic                      req;
    logic [ram_addr_width-1:0] addr;
  } instr_req_t;

  // ram view: everything above the offset must be zero for a hit
  typedef struct packed {
    logic [data_width-ram_addr_width-1:0] high;
    logic [ram_addr_width-1:0]            offset;
  } ram_view_t;

  // peripheral view: 64 KiB regions
  typedef struct packed {
    logic [15:0] region;
    logic [15:0] reg_off;
  } per_view_t;

  typedef union packed {
    ram_view_t ram;
    per_view_t per;
  } data_addr_u;

  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [data_be_width-1:0] be;
    data_addr_u               addr;
    logic [data_width-1:0]    wdata;
  } data_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic                  err;
    logic [data_width-1:0] rdata;
  } data_rsp_t;

endpackage

//--- verilog/mem_map_pkg.sv
/*
 * Address map of the pseudo peripherals behind the data port.
 * Control registers are write only; reads there are treated as unmapped.
 * The timer interrupt id doubles as the enable bit index in the mask.
 */
package mem_map_pkg;

  // control registers, full 32-bit match
  localparam logic [31:0] status_addr     = 32'h2000_0000;
  localparam logic [31:0] exit_addr       = 32'h2000_0004;
  localparam logic [31:0] timer_mask_addr = 32'h1500_0000;
  localparam logic [31:0] timer_cnt_addr  = 32'h1500_0004;

  // scratch bank occupies a whole 64 KiB region
  localparam logic [15:0] scratch_region = 16'h1600;

  localparam logic [31:0] pass_magic = 32'd123456789;
  localparam logic [31:0] fail_magic = 32'd1;

  localparam int timer_irq_id  = 7;
  localparam int scratch_count = 16;

  // one strobe per control register, only one can be high at a time
  typedef struct packed {
    logic        status_we;
    logic        exit_we;
    logic        mask_we;
    logic        cnt_we;
    logic [31:0] wdata;
  } ctrl_wr_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  idx;
    logic [31:0] wdata;
  } scratch_req_t;

endpackage

//--- verilog/dp_ram.sv
/*
 * Byte-addressed dual-port RAM. The instruction port reads a whole
 * aligned line, the data port an aligned word with byte-enabled writes.
 * Both reads return one cycle after the enable; a read in the cycle of a
 * write to the same bytes sees the old contents.
 */
`timescale 1ns/1ps

module dp_ram
  import bus_pkg::*;
(
  input  logic                         clk_i,

  input  logic                         instr_en_i,
  input  logic [ram_addr_width-1:0]    instr_addr_i,
  output logic [instr_rdata_width-1:0] instr_rdata_o,

  input  logic                         data_en_i,
  input  logic                         data_we_i,
  input  logic [data_be_width-1:0]     data_be_i,
  input  logic [ram_addr_width-1:0]    data_addr_i,
  input  logic [data_width-1:0]        data_wdata_i,
  output logic [data_width-1:0]        data_rdata_o
);

  localparam int ram_bytes  = 2 ** ram_addr_width;
  localparam int line_bytes = instr_rdata_width / 8;
  localparam int line_lsb   = $clog2(line_bytes);
  localparam int word_lsb   = $clog2(data_be_width);

  logic [7:0] mem [ram_bytes];

  logic [ram_addr_width-1:0] line_base;
  logic [ram_addr_width-1:0] word_base;

  // drop the low address bits, fetch and data are always aligned
  assign line_base = {instr_addr_i[ram_addr_width-1:line_lsb], {line_lsb{1'b0}}};
  assign word_base = {data_addr_i[ram_addr_width-1:word_lsb], {word_lsb{1'b0}}};

  // instruction line, byte 0 in the low lane
  always_ff @(posedge clk_i) begin
    if (instr_en_i) begin
      for (int i = 0; i < line_bytes; i++) begin
        instr_rdata_o[8*i +: 8] <= mem[line_base + ram_addr_width'(i)];
      end
    end
  end

  // data word, write only the enabled lanes
  always_ff @(posedge clk_i) begin
    if (data_en_i) begin
      for (int i = 0; i < data_be_width; i++) begin
        if (data_we_i && data_be_i[i]) begin
          mem[word_base + ram_addr_width'(i)] <= data_wdata_i[8*i +: 8];
        end
        data_rdata_o[8*i +: 8] <= mem[word_base + ram_addr_width'(i)];
      end
    end
  end

endmodule

//--- verilog/addr_decoder.sv
/*
 * Data port decoder. Every request is granted in its own cycle, mapped or
 * not, and answered one cycle later. Unmapped accesses come back with err
 * set and zero read data. Control registers only decode for writes.
 */
`timescale 1ns/1ps

module addr_decoder
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  data_req_t                 data_req_i,

  output logic                      ram_en_o,
  output logic                      ram_we_o,
  output logic [data_be_width-1:0]  ram_be_o,
  output logic [ram_addr_width-1:0] ram_addr_o,
  output logic [data_width-1:0]     ram_wdata_o,
  input  logic [data_width-1:0]     ram_rdata_i,

  output ctrl_wr_t                  ctrl_wr_o,

  output scratch_req_t              scratch_req_o,
  input  logic [data_width-1:0]     scratch_rdata_i,

  output data_rsp_t                 data_rsp_o
);

  typedef enum logic [1:0] {
    tgt_ram,
    tgt_ctrl,
    tgt_scratch,
    tgt_err
  } target_e;

  target_e    target;
  target_e    target_q;
  logic       valid_q;
  logic       is_ctrl;
  logic       ctrl_sel;
  data_addr_u addr;

  assign addr = data_req_i.addr;

  assign is_ctrl = (addr == status_addr) || (addr == exit_addr) ||
                   (addr == timer_mask_addr) || (addr == timer_cnt_addr);

  // ram has priority, then scratch, then the write-only control block
  always_comb begin
    target = tgt_err;
    if (addr.ram.high == '0) begin
      target = tgt_ram;
    end else if (addr.per.region == scratch_region) begin
      target = tgt_scratch;
    end else if (data_req_i.we && is_ctrl) begin
      target = tgt_ctrl;
    end
  end

  // ram port, only the enable is qualified
  assign ram_en_o    = data_req_i.req && (target == tgt_ram);
  assign ram_we_o    = data_req_i.we;
  assign ram_be_o    = data_req_i.be;
  assign ram_addr_o  = addr.ram.offset;
  assign ram_wdata_o = data_req_i.wdata;

  assign ctrl_sel = data_req_i.req && (target == tgt_ctrl);

  always_comb begin
    ctrl_wr_o.status_we = ctrl_sel && (addr == status_addr);
    ctrl_wr_o.exit_we   = ctrl_sel && (addr == exit_addr);
    ctrl_wr_o.mask_we   = ctrl_sel && (addr == timer_mask_addr);
    ctrl_wr_o.cnt_we    = ctrl_sel && (addr == timer_cnt_addr);
    ctrl_wr_o.wdata     = data_req_i.wdata;
  end

  // word index inside the region, upper offset bits alias
  always_comb begin
    scratch_req_o.req   = data_req_i.req && (target == tgt_scratch);
    scratch_req_o.we    = data_req_i.we;
    scratch_req_o.idx   = addr.per.reg_off[5:2];
    scratch_req_o.wdata = data_req_i.wdata;
  end

  // remember where the response has to come from
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      target_q <= tgt_ram;
    end else begin
      valid_q  <= data_req_i.req;
      target_q <= target;
    end
  end

  always_comb begin
    data_rsp_o.gnt    = data_req_i.req;
    data_rsp_o.rvalid = valid_q;
    data_rsp_o.err    = valid_q && (target_q == tgt_err);
    data_rsp_o.rdata  = '0;
    if (valid_q) begin
      case (target_q)
        tgt_ram:     data_rsp_o.rdata = ram_rdata_i;
        tgt_scratch: data_rsp_o.rdata = scratch_rdata_i;
        default:     data_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

//--- verilog/sim_ctrl.sv
/*
 * Test status, exit code and a countdown timer with one interrupt.
 * Status and exit strobes are single-cycle pulses one cycle after the
 * write. Only bit timer_irq_id of the mask is stored.
 */
`timescale 1ns/1ps

module sim_ctrl
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  ctrl_wr_t              ctrl_wr_i,

  input  logic                  irq_ack_i,
  input  logic [4:0]            irq_id_i,

  output logic                  tests_passed_o,
  output logic                  tests_failed_o,
  output logic                  exit_valid_o,
  output logic [data_width-1:0] exit_value_o,
  output logic                  irq_timer_o
);

  logic        mask_en_q;
  logic [31:0] cnt_q;
  logic        timer_fire;
  logic        timer_ack;

  // counter reaches zero at this edge, a reload cancels it
  assign timer_fire = !ctrl_wr_i.cnt_we && (cnt_q == 32'd1) && mask_en_q;
  assign timer_ack  = irq_ack_i && (irq_id_i == 5'(timer_irq_id));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_valid_o   <= 1'b0;
      exit_value_o   <= '0;
    end else begin
      tests_passed_o <= ctrl_wr_i.status_we && (ctrl_wr_i.wdata == pass_magic);
      tests_failed_o <= ctrl_wr_i.status_we && (ctrl_wr_i.wdata == fail_magic);
      exit_valid_o   <= ctrl_wr_i.exit_we;
      if (ctrl_wr_i.exit_we) begin
        exit_value_o <= ctrl_wr_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_en_q   <= 1'b0;
      cnt_q       <= '0;
      irq_timer_o <= 1'b0;
    end else begin
      if (ctrl_wr_i.mask_we) begin
        mask_en_q <= ctrl_wr_i.wdata[timer_irq_id];
      end

      if (ctrl_wr_i.cnt_we) begin
        cnt_q <= ctrl_wr_i.wdata;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 32'd1;
      end

      // ack wins over a set in the same cycle
      if (timer_ack) begin
        irq_timer_o <= 1'b0;
      end else if (timer_fire) begin
        irq_timer_o <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/scratch_regs.sv
/*
 * Sixteen general purpose 32-bit registers. Indexed by address bits 5:2,
 * so the bank repeats every 64 bytes across its region. Read data is
 * registered at the request edge and shows up on the next cycle.
 */
`timescale 1ns/1ps

module scratch_regs
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  scratch_req_t          scratch_req_i,
  output logic [data_width-1:0] rdata_o
);

  logic [data_width-1:0] regs [scratch_count];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < scratch_count; i++) begin
        regs[i] <= '0;
      end
      rdata_o <= '0;
    end else if (scratch_req_i.req) begin
      if (scratch_req_i.we) begin
        regs[scratch_req_i.idx] <= scratch_req_i.wdata;
      end else begin
        rdata_o <= regs[scratch_req_i.idx];
      end
    end
  end

endmodule

//--- verilog/mm_ram_top.sv
/*
 * Memory-mapped simulation memory for a small RISC-V core.
 * 64 KiB RAM with a 128-bit fetch port and a 32-bit data port, plus test
 * status, exit code, a timer interrupt and scratch registers.
 * No back-pressure: both ports grant in the request cycle.
 */
`timescale 1ns/1ps

module mm_ram_top
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  instr_req_t                   instr_req_i,
  output logic                         instr_gnt_o,
  output logic                         instr_rvalid_o,
  output logic [instr_rdata_width-1:0] instr_rdata_o,

  input  data_req_t                    data_req_i,
  output data_rsp_t                    data_rsp_o,

  input  logic                         irq_ack_i,
  input  logic [4:0]                   irq_id_i,
  output logic                         irq_timer_o,

  output logic                         tests_passed_o,
  output logic                         tests_failed_o,
  output logic                         exit_valid_o,
  output logic [data_width-1:0]        exit_value_o
);

  logic                      ram_en;
  logic                      ram_we;
  logic [data_be_width-1:0]  ram_be;
  logic [ram_addr_width-1:0] ram_addr;
  logic [data_width-1:0]     ram_wdata;
  logic [data_width-1:0]     ram_rdata;
  logic [data_width-1:0]     scratch_rdata;
  ctrl_wr_t                  ctrl_wr;
  scratch_req_t              scratch_req;

  // fetch never stalls, data follows one cycle later
  assign instr_gnt_o = instr_req_i.req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_o <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_req_i.req;
    end
  end

  dp_ram u_dp_ram (
    .clk_i        (clk_i),
    .instr_en_i   (instr_req_i.req),
    .instr_addr_i (instr_req_i.addr),
    .instr_rdata_o(instr_rdata_o),
    .data_en_i    (ram_en),
    .data_we_i    (ram_we),
    .data_be_i    (ram_be),
    .data_addr_i  (ram_addr),
    .data_wdata_i (ram_wdata),
    .data_rdata_o (ram_rdata)
  );

  addr_decoder u_addr_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_be_o       (ram_be),
    .ram_addr_o     (ram_addr),
    .ram_wdata_o    (ram_wdata),
    .ram_rdata_i    (ram_rdata),
    .ctrl_wr_o      (ctrl_wr),
    .scratch_req_o  (scratch_req),
    .scratch_rdata_i(scratch_rdata),
    .data_rsp_o     (data_rsp_o)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_wr_i     (ctrl_wr),
    .irq_ack_i     (irq_ack_i),
    .irq_id_i      (irq_id_i),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .irq_timer_o   (irq_timer_o)
  );

  scratch_regs u_scratch_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .scratch_req_i(scratch_req),
    .rdata_o      (scratch_rdata)
  );

endmodule

//--- test/mm_ram_asserts.sv
/*
 * Handshake checks bound into mm_ram_top.
 * Sampled on the rising clock edge, off while reset is low.
 */
`timescale 1ns/1ps

module mm_ram_asserts
  import bus_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input instr_req_t instr_req_i,
  input logic       instr_rvalid_o,
  input data_rsp_t  data_rsp_o,
  input logic       tests_passed_o,
  input logic       tests_failed_o
);

  // a data response always answers the grant of the previous cycle
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rsp_o.rvalid |-> $past(data_rsp_o.gnt))
    else $error("data rvalid without a grant in the previous cycle");

  gnt_gets_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rsp_o.gnt |=> data_rsp_o.rvalid)
    else $error("granted data request got no rvalid one cycle later");

  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rsp_o.err |-> data_rsp_o.rvalid)
    else $error("data err raised without rvalid");

  instr_rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_o |-> $past(instr_req_i.req))
    else $error("instruction rvalid without a request in the previous cycle");

  pass_fail_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tests_passed_o && tests_failed_o))
    else $error("passed and failed pulses high in the same cycle");

endmodule

bind mm_ram_top mm_ram_asserts u_mm_ram_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_req_i   (instr_req_i),
  .instr_rvalid_o(instr_rvalid_o),
  .data_rsp_o    (data_rsp_o),
  .tests_passed_o(tests_passed_o),
  .tests_failed_o(tests_failed_o)
);

//--- test/tb_mm_ram.sv
/*
 * Testbench for mm_ram_top. Random traffic from a fixed xorshift seed is
 * compared every cycle with a model of the RAM, scratch bank and control
 * block. RAM traffic stays inside a 512-byte window that is filled first.
 */
`timescale 1ns/1ps

module tb_mm_ram
  import bus_pkg::*;
  import mem_map_pkg::*;
();

  localparam logic [15:0] ram_win_base  = 16'h2000;
  localparam int          ram_win_words = 128;
  localparam int ram_ops      = 400;
  localparam int fetch_ops    = 200;
  localparam int scratch_ops  = 300;
  localparam int status_ops   = 40;
  localparam int timer_rounds = 12;
  localparam int timer_len    = 50;
  localparam int unmap_ops    = 200;
  // reset, each test with its drain cycles, then a margin
  localparam int cycle_limit = 16 + ram_win_words + 2 * ram_ops + fetch_ops + scratch_ops +
                               status_ops + timer_rounds * timer_len + unmap_ops + 12 + 500;

  typedef struct packed {
    logic        rvalid;
    logic        err;
    logic        chk_rdata;
    logic [31:0] rdata;
  } exp_rsp_t;

  logic         clk_i;
  logic         rst_ni;
  instr_req_t   instr_req;
  logic         instr_gnt;
  logic         instr_rvalid;
  logic [127:0] instr_rdata;
  data_req_t    data_req;
  data_rsp_t    data_rsp;
  logic         irq_ack;
  logic [4:0]   irq_id;
  logic         irq_timer;
  logic         tests_passed;
  logic         tests_failed;
  logic         exit_valid;
  logic [31:0]  exit_value;

  // reference model state
  logic [7:0]   ram_model [65536];
  logic [31:0]  scratch_model [scratch_count];
  logic         mask_model;
  logic [31:0]  cnt_model;
  logic         irq_model;
  logic [31:0]  exit_model;
  logic         pass_exp;
  logic         fail_exp;
  logic         exit_exp;
  logic         irv_exp;
  logic [127:0] line_exp;
  exp_rsp_t     rsp_q [$];

  // inputs that the DUT samples at the next edge
  instr_req_t   prev_instr;
  data_req_t    prev_data;
  logic         prev_ack;
  logic [4:0]   prev_id;

  logic [31:0]  rng_state;
  int           checks;
  int           errors;
  int           test_count;
  int           test_errors;
  int           cycle_cnt = 0;
  bit           report_done = 1'b0;
  bit           timed_out = 1'b0;

  mm_ram_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_req_i   (instr_req),
    .instr_gnt_o   (instr_gnt),
    .instr_rvalid_o(instr_rvalid),
    .instr_rdata_o (instr_rdata),
    .data_req_i    (data_req),
    .data_rsp_o    (data_rsp),
    .irq_ack_i     (irq_ack),
    .irq_id_i      (irq_id),
    .irq_timer_o   (irq_timer),
    .tests_passed_o(tests_passed),
    .tests_failed_o(tests_failed),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      timed_out = 1'b1;
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  final begin
    if (!report_done && !timed_out) begin
      $display("TEST FAILED");
    end
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] win_addr(input logic [31:0] r);
    return {16'h0, ram_win_base | {7'h0, r[8:0]}};
  endfunction

  function automatic data_req_t make_req(input logic we, input logic [3:0] be,
                                         input logic [31:0] addr, input logic [31:0] wdata);
    data_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // 0 ram, 1 control, 2 scratch, 3 unmapped
  function automatic logic [1:0] target_of(input logic [31:0] addr, input logic we);
    if (addr[31:16] == 16'h0) return 2'd0;
    if (addr[31:16] == scratch_region) return 2'd2;
    if (we && (addr == status_addr || addr == exit_addr || addr == timer_mask_addr ||
               addr == timer_cnt_addr)) return 2'd1;
    return 2'd3;
  endfunction

  function automatic logic [31:0] ram_word(input logic [15:0] addr);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = ram_model[{addr[15:2], 2'b00} + 16'(i)];
    end
    return w;
  endfunction

  function automatic logic [127:0] ram_line(input logic [15:0] addr);
    logic [127:0] l;
    for (int i = 0; i < 16; i++) begin
      l[8*i +: 8] = ram_model[{addr[15:4], 4'h0} + 16'(i)];
    end
    return l;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s: expected %0h, got %0h", name, exp, got);
    end
  endtask

  // one clock edge of the model, fed with what the DUT samples there
  task automatic model_edge();
    exp_rsp_t    e;
    logic [1:0]  tgt;
    logic [31:0] a;
    logic [31:0] wd;
    logic        ctrl;
    logic        cnt_we;
    logic        fire;
    logic        ack;
    a   = prev_data.addr;
    wd  = prev_data.wdata;
    tgt = target_of(a, prev_data.we);
    irv_exp = prev_instr.req;
    if (prev_instr.req) begin
      line_exp = ram_line(prev_instr.addr);
    end
    e.rvalid    = prev_data.req;
    e.err       = prev_data.req && (tgt == 2'd3);
    e.chk_rdata = prev_data.req && (!prev_data.we || tgt == 2'd3);
    e.rdata     = '0;
    if (tgt == 2'd0) e.rdata = ram_word(a[15:0]);
    if (tgt == 2'd2) e.rdata = scratch_model[a[5:2]];
    rsp_q.push_back(e);
    if (prev_data.req && prev_data.we && tgt == 2'd0) begin
      for (int i = 0; i < 4; i++) begin
        if (prev_data.be[i]) ram_model[{a[15:2], 2'b00} + 16'(i)] = wd[8*i +: 8];
      end
    end
    if (prev_data.req && prev_data.we && tgt == 2'd2) begin
      scratch_model[a[5:2]] = wd;
    end
    ctrl     = prev_data.req && prev_data.we && (tgt == 2'd1);
    pass_exp = ctrl && (a == status_addr) && (wd == pass_magic);
    fail_exp = ctrl && (a == status_addr) && (wd == fail_magic);
    exit_exp = ctrl && (a == exit_addr);
    if (exit_exp) exit_model = wd;
    cnt_we = ctrl && (a == timer_cnt_addr);
    fire   = !cnt_we && (cnt_model == 32'd1) && mask_model;
    ack    = prev_ack && (prev_id == 5'(timer_irq_id));
    // ack beats a set on the same edge
    if (ack) begin
      irq_model = 1'b0;
    end else if (fire) begin
      irq_model = 1'b1;
    end
    if (cnt_we) begin
      cnt_model = wd;
    end else if (cnt_model != 32'd0) begin
      cnt_model = cnt_model - 32'd1;
    end
    if (ctrl && a == timer_mask_addr) mask_model = wd[timer_irq_id];
  endtask

  task automatic tick(input instr_req_t ni, input data_req_t nd, input logic nack,
                      input logic [4:0] nid);
    exp_rsp_t e;
    @(posedge clk_i);
    instr_req <= ni;
    data_req  <= nd;
    irq_ack   <= nack;
    irq_id    <= nid;
    model_edge();
    prev_instr = ni;
    prev_data  = nd;
    prev_ack   = nack;
    prev_id    = nid;
    @(negedge clk_i);
    e = rsp_q.pop_front();
    check("data_rsp_o.gnt", 128'(data_rsp.gnt), 128'(nd.req));
    check("data_rsp_o.rvalid", 128'(data_rsp.rvalid), 128'(e.rvalid));
    check("data_rsp_o.err", 128'(data_rsp.err), 128'(e.err));
    if (e.chk_rdata) check("data_rsp_o.rdata", 128'(data_rsp.rdata), 128'(e.rdata));
    check("instr_gnt_o", 128'(instr_gnt), 128'(ni.req));
    check("instr_rvalid_o", 128'(instr_rvalid), 128'(irv_exp));
    if (irv_exp) check("instr_rdata_o", instr_rdata, line_exp);
    check("tests_passed_o", 128'(tests_passed), 128'(pass_exp));
    check("tests_failed_o", 128'(tests_failed), 128'(fail_exp));
    check("exit_valid_o", 128'(exit_valid), 128'(exit_exp));
    check("exit_value_o", 128'(exit_value), 128'(exit_model));
    check("irq_timer_o", 128'(irq_timer), 128'(irq_model));
  endtask

  task automatic idle(input int n);
    repeat (n) tick('0, '0, 1'b0, 5'd0);
  endtask

  task automatic data_op(input logic we, input logic [3:0] be, input logic [31:0] addr,
                         input logic [31:0] wdata);
    tick('0, make_req(we, be, addr, wdata), 1'b0, 5'd0);
  endtask

  task automatic end_test(input string name);
    idle(2);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [4:0]  id;
    logic        mask_bit;
    int          n;
    instr_req_t  fetch;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    instr_req  = '0;
    data_req   = '0;
    irq_ack    = 1'b0;
    irq_id     = '0;
    prev_instr = '0;
    prev_data  = '0;
    prev_ack   = 1'b0;
    prev_id    = '0;
    rng_state  = 32'h264c;
    mask_model = 1'b0;
    cnt_model  = '0;
    irq_model  = 1'b0;
    exit_model = '0;
    pass_exp   = 1'b0;
    fail_exp   = 1'b0;
    exit_exp   = 1'b0;
    irv_exp    = 1'b0;
    line_exp   = '0;
    checks      = 0;
    errors      = 0;
    test_count  = 0;
    test_errors = 0;
    for (int i = 0; i < scratch_count; i++) begin
      scratch_model[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // fill the window, then partial writes each followed by a read
    for (int i = 0; i < ram_win_words; i++) begin
      data_op(1'b1, 4'hf, win_addr(32'(4 * i)), rand32());
    end
    for (int i = 0; i < ram_ops; i++) begin
      r = rand32();
      a = win_addr(r);
      data_op(1'b1, r[12:9], a, rand32());
      r = rand32();
      data_op(1'b0, 4'h0, r[31] ? a : win_addr(r), 32'h0);
    end
    end_test("ram write/read");

    for (int i = 0; i < fetch_ops; i++) begin
      r = rand32();
      fetch.req  = r[20] | r[21];
      fetch.addr = ram_win_base | {7'h0, r[8:0]};
      tick(fetch, '0, 1'b0, 5'd0);
    end
    end_test("instruction fetch");

    // 16-bit offsets, so indices alias across the whole region
    for (int i = 0; i < scratch_ops; i++) begin
      r = rand32();
      data_op(r[16], 4'hf, {scratch_region, r[15:0]}, rand32());
    end
    end_test("scratch registers");

    for (int i = 0; i < status_ops; i++) begin
      r = rand32();
      case (r[2:0])
        3'd0, 3'd1: data_op(1'b1, 4'hf, status_addr, pass_magic);
        3'd2:       data_op(1'b1, 4'hf, status_addr, fail_magic);
        3'd3, 3'd4: data_op(1'b1, 4'hf, status_addr, rand32());
        3'd5, 3'd6: data_op(1'b1, 4'hf, exit_addr, rand32());
        default:    idle(1);
      endcase
    end
    end_test("status and exit");

    for (int k = 0; k < timer_rounds; k++) begin
      r = rand32();
      mask_bit = r[0];
      r[timer_irq_id] = mask_bit;
      data_op(1'b1, 4'hf, timer_mask_addr, r);
      n = 2 + int'(rand32() % 32'd39);
      data_op(1'b1, 4'hf, timer_cnt_addr, 32'(n));
      // loaded one edge after the write, then n edges down to zero
      idle(n + 1);
      check("irq_timer_o after countdown", 128'(irq_timer), 128'(mask_bit));
      r  = rand32();
      id = (r[4:0] == 5'(timer_irq_id)) ? 5'd8 : r[4:0];
      tick('0, '0, 1'b1, id);
      idle(1);
      check("irq_timer_o after wrong ack", 128'(irq_timer), 128'(mask_bit));
      tick('0, '0, 1'b1, 5'(timer_irq_id));
      idle(1);
      check("irq_timer_o after ack", 128'(irq_timer), 128'h0);
    end
    end_test("timer interrupt");

    for (int i = 0; i < unmap_ops; i++) begin
      r = rand32();
      a = rand32();
      if (r[1:0] == 2'd0) begin
        // old signature range registers
        a = 32'h2000_0008 + {28'h0, r[3:2], 2'b00};
      end else if (r[1:0] == 2'd1) begin
        a = r[4] ? timer_cnt_addr : status_addr;
      end else if (a[31:16] == 16'h0 || a[31:16] == scratch_region) begin
        a[31:16] = 16'hdead;
      end
      data_op((r[1:0] != 2'd1) && r[8], r[7:4], a, rand32());
    end
    end_test("unmapped access");

    report_done = 1'b1;
    $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/bus_pkg.sv
verilog/mem_map_pkg.sv
verilog/dp_ram.sv
verilog/addr_decoder.sv
verilog/sim_ctrl.sv
verilog/scratch_regs.sv
verilog/mm_ram_top.sv
test/mm_ram_asserts.sv
test/tb_mm_ram.sv

//--- run.sh
#!/bin/sh
# build and run the mm_ram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_mm_ram -o tb_mm_ram

output=$(./obj_dir/tb_mm_ram 2>&1) || {
  echo "$output"
  exit 1
}
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
